// ==== build.f ====
+incdir+design
design/ext_mem_storage_pkg.sv
design/ext_mem_cmd_pkg.sv
design/ext_mem_cmd_if.sv
design/conduit_decoder.sv
design/mem_array.sv
design/read_delay_line.sv
design/ext_mem_top.sv
verif/ext_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module ext_mem_tb -f build.f > sim.log 2>&1 \
   && ./obj_dir/Vext_mem_tb >> sim.log 2>&1 \
   || echo "TEST FAIL" >> sim.log

cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// ==== verif/ext_mem_tb.sv ====
`timescale 1ns/1ns

`include "ext_mem_settings.svh"

module ext_mem_tb;

   localparam int period        = 100;
   localparam int reset_cycles  = 5;
   localparam int latency       = `EXT_MEM_READ_LATENCY;
   localparam int addr_w        = `EXT_MEM_ADDR_W;
   localparam int num_symbols   = `EXT_MEM_NUM_SYMBOLS;
   localparam int symbol_w      = `EXT_MEM_SYMBOL_W;
   localparam int data_w        = num_symbols * symbol_w;
   localparam int sym_lsb       = $clog2(num_symbols);
   localparam int word_addr_w   = addr_w - sym_lsb;
   localparam int num_words     = 2 ** word_addr_w;
   localparam int num_random    = 12;
   localparam int margin_cycles = 20;

   // pin polarity, 1 means the pin is low when active
   localparam bit low_cs = (`EXT_MEM_ACTIVE_LOW_CS != 0);
   localparam bit low_rd = (`EXT_MEM_ACTIVE_LOW_READ != 0);
   localparam bit low_wr = (`EXT_MEM_ACTIVE_LOW_WRITE != 0);
   localparam bit low_oe = (`EXT_MEM_ACTIVE_LOW_OE != 0);
   localparam bit low_be = (`EXT_MEM_ACTIVE_LOW_BYTEEN != 0);

   typedef enum logic [1:0] {op_idle, op_write, op_read} op_t;

   // one table row, all controls in logical (active high) form
   typedef struct packed {
      op_t                    op;
      logic                   cs;
      logic                   oe;
      logic [addr_w-1:0]      addr;
      logic [num_symbols-1:0] be;
      logic [data_w-1:0]      data;
      logic [data_w-1:0]      exp;
      bit                     exp_from_ref;
   } step_t;

   // expected pin values for one cycle
   typedef struct packed {
      logic              drive;
      logic [data_w-1:0] data;
      int                row;
   } result_t;

   logic                   clk;
   logic                   internal_reset;
   logic [addr_w-1:0]      address;
   logic [data_w-1:0]      wdata;
   logic [num_symbols-1:0] byteenable;
   logic                   chipselect;
   logic                   read;
   logic                   write;
   logic                   outputenable;
   logic [data_w-1:0]      rdata;
   logic                   rdrive;

   // reference copy of the array contents
   logic [data_w-1:0] ref_mem [num_words];

   step_t   table_q [$];
   result_t expect_q [$];
   step_t   idle_step;
   integer  seed;
   bit      table_ready;

   ext_mem_top uut (
      .clk            (clk),
      .internal_reset (internal_reset),
      .address        (address),
      .wdata          (wdata),
      .byteenable     (byteenable),
      .chipselect     (chipselect),
      .read           (read),
      .write          (write),
      .outputenable   (outputenable),
      .rdata          (rdata),
      .rdrive         (rdrive)
   );

   always #(period / 2) clk = ~clk;

   // ----------------------------------------
   // helpers
   // ----------------------------------------

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   // bit b belongs to symbol b / symbol_w
   function automatic logic [data_w-1:0] widen_enables(input logic [num_symbols-1:0] be);
      logic [data_w-1:0] mask;
      for (int b = 0; b < data_w; b++) begin
         mask[b] = be[b / symbol_w];
      end
      return mask;
   endfunction

   function automatic step_t make_step(input op_t op, input logic cs, input logic oe,
                                       input logic [addr_w-1:0] addr,
                                       input logic [num_symbols-1:0] be,
                                       input logic [data_w-1:0] data,
                                       input logic [data_w-1:0] exp, input bit from_ref);
      step_t s;
      s.op           = op;
      s.cs           = cs;
      s.oe           = oe;
      s.addr         = addr;
      s.be           = be;
      s.data         = data;
      s.exp          = exp;
      s.exp_from_ref = from_ref;
      return s;
   endfunction

   // row with a hand-derived expected rdata
   function automatic void add_step(input op_t op, input logic cs, input logic oe,
                                    input logic [addr_w-1:0] addr,
                                    input logic [num_symbols-1:0] be,
                                    input logic [data_w-1:0] data,
                                    input logic [data_w-1:0] exp);
      table_q.push_back(make_step(op, cs, oe, addr, be, data, exp, 1'b0));
   endfunction

   // ----------------------------------------
   // stimulus table
   // ----------------------------------------

   task automatic build_table();
      logic [31:0]       rnd;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic [num_symbols-1:0] be;
      // fresh array reads back zero, idle never drives
      add_step(op_read,  1'b1, 1'b1, 8'h00, 4'b1111, 32'h0,        32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'h44, 4'b1111, 32'h0,        32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'hfc, 4'b1111, 32'h0,        32'h0);
      add_step(op_idle,  1'b1, 1'b1, 8'h00, 4'b1111, 32'h0,        32'h0);
      // full word writes then reads
      add_step(op_write, 1'b1, 1'b1, 8'h10, 4'b1111, 32'h11223344, 32'h0);
      add_step(op_write, 1'b1, 1'b1, 8'h20, 4'b1111, 32'ha5a55a5a, 32'h0);
      add_step(op_write, 1'b1, 1'b1, 8'h30, 4'b1111, 32'hdeadbeef, 32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'h10, 4'b1111, 32'h0,        32'h11223344);
      add_step(op_idle,  1'b1, 1'b1, 8'h10, 4'b1111, 32'h0,        32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'h20, 4'b1111, 32'h0,        32'ha5a55a5a);
      add_step(op_read,  1'b1, 1'b1, 8'h30, 4'b1111, 32'h0,        32'hdeadbeef);
      // partial writes merge into the old word
      add_step(op_write, 1'b1, 1'b1, 8'h10, 4'b0011, 32'hffffcafe, 32'h0);
      add_step(op_write, 1'b1, 1'b1, 8'h10, 4'b1000, 32'h77000000, 32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'h10, 4'b1111, 32'h0,        32'h7722cafe);
      // partial reads zero the disabled lanes, low address bits ignored
      add_step(op_read,  1'b1, 1'b1, 8'h10, 4'b0101, 32'h0,        32'h002200fe);
      add_step(op_read,  1'b1, 1'b1, 8'h12, 4'b1010, 32'h0,        32'h7700ca00);
      // back to back reads, several in flight
      add_step(op_read,  1'b1, 1'b1, 8'h20, 4'b1111, 32'h0,        32'ha5a55a5a);
      add_step(op_read,  1'b1, 1'b1, 8'h30, 4'b1111, 32'h0,        32'hdeadbeef);
      add_step(op_read,  1'b1, 1'b1, 8'h10, 4'b1111, 32'h0,        32'h7722cafe);
      add_step(op_read,  1'b1, 1'b1, 8'h04, 4'b1111, 32'h0,        32'h0);
      // oe low or cs low gives no drive, write without cs is dropped
      add_step(op_read,  1'b1, 1'b0, 8'h20, 4'b1111, 32'h0,        32'h0);
      add_step(op_read,  1'b0, 1'b1, 8'h20, 4'b1111, 32'h0,        32'h0);
      add_step(op_write, 1'b0, 1'b1, 8'h20, 4'b1111, 32'h0badf00d, 32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'h20, 4'b1111, 32'h0,        32'ha5a55a5a);
      // idle with write pin high and busy data lines
      add_step(op_idle,  1'b1, 1'b1, 8'h30, 4'b1111, 32'hffffffff, 32'h0);
      add_step(op_idle,  1'b1, 1'b1, 8'h30, 4'b1111, 32'hffffffff, 32'h0);
      add_step(op_idle,  1'b1, 1'b1, 8'h30, 4'b1111, 32'hffffffff, 32'h0);
      add_step(op_read,  1'b1, 1'b1, 8'h30, 4'b1111, 32'h0,        32'hdeadbeef);
      // random writes, each read back at once
      for (int i = 0; i < num_random; i++) begin
         rnd  = $random(seed);
         addr = addr_w'(rnd);
         rnd  = $random(seed);
         data = data_w'(rnd);
         rnd  = $random(seed);
         be   = num_symbols'(rnd);
         table_q.push_back(make_step(op_write, 1'b1, 1'b1, addr, be, data, '0, 1'b1));
         table_q.push_back(make_step(op_read, 1'b1, 1'b1, addr, '1, '0, '0, 1'b1));
      end
   endtask

   // ----------------------------------------
   // drive, predict, check
   // ----------------------------------------

   // logical controls to pin levels
   task automatic drive_step(input step_t s);
      address      = s.addr;
      wdata        = s.data;
      byteenable   = s.be ^ {num_symbols{low_be}};
      chipselect   = s.cs ^ low_cs;
      read         = (s.op == op_read) ^ low_rd;
      write        = (s.op == op_write) ^ low_wr;
      outputenable = s.oe ^ low_oe;
   endtask

   task automatic predict(input step_t s, input int row);
      result_t                r;
      logic [word_addr_w-1:0] idx;
      logic [data_w-1:0]      mask;
      idx   = s.addr[addr_w-1:sym_lsb];
      mask  = widen_enables(s.be);
      r.row = row;
      // bus is driven only by an enabled, selected read
      r.drive = (s.op == op_read) && s.cs && s.oe;
      r.data  = r.drive ? (ref_mem[idx] & mask) : '0;
      if (!s.exp_from_ref) begin
         assert (s.exp == r.data) else
            report_failure($sformatf("table row %0d expects %h but the reference array gives %h",
                                     row, s.exp, r.data));
      end
      // write lands at the coming edge, later reads see it
      if (s.op == op_write && s.cs) begin
         ref_mem[idx] = (ref_mem[idx] & ~mask) | (s.data & mask);
      end
      expect_q.push_back(r);
   endtask

   task automatic check_outputs();
      result_t r;
      r = expect_q.pop_front();
      assert (rdrive === r.drive) else
         report_failure($sformatf("mismatch rdrive at row %0d got %h expected %h",
                                  r.row, rdrive, r.drive));
      assert (rdata === r.data) else
         report_failure($sformatf("mismatch rdata at row %0d got %h expected %h",
                                  r.row, rdata, r.data));
   endtask

   // one cycle, called on the falling edge
   task automatic apply_cycle(input step_t s, input int row);
      drive_step(s);
      predict(s, row);
      #1;
      // oldest entry is due once latency cycles have passed
      if (expect_q.size() > latency) begin
         check_outputs();
      end
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------

   initial begin
      clk            = 1'b0;
      internal_reset = 1'b1;
      seed           = 83;
      table_ready    = 1'b0;
      idle_step      = make_step(op_idle, 1'b0, 1'b0, '0, '0, '0, '0, 1'b1);
      drive_step(idle_step);
      for (int w = 0; w < num_words; w++) begin
         ref_mem[w] = '0;
      end
      build_table();
      table_ready = 1'b1;
      repeat (reset_cycles) @(negedge clk);
      internal_reset = 1'b0;
      for (int r = 0; r < table_q.size(); r++) begin
         apply_cycle(table_q[r], r);
         @(negedge clk);
      end
      // flush reads still in the pipe
      repeat (latency) begin
         apply_cycle(idle_step, -1);
         @(negedge clk);
      end
      $display("TEST PASS");
      $finish;
   end

   // watchdog sized from the table
   initial begin
      int limit_ns;
      wait (table_ready);
      limit_ns = (table_q.size() + latency + reset_cycles + margin_cycles) * period;
      #(limit_ns);
      report_failure($sformatf("the run timed out after %0d ns", limit_ns));
   end

endmodule

// ==== design/ext_mem_top.sv ====
`timescale 1ns/1ns

`include "ext_mem_settings.svh"

module ext_mem_top (
   input  logic                        clk,
   input  logic                        internal_reset,

   // conduit pins, polarity as given in the settings header
   input  logic [`EXT_MEM_ADDR_W-1:0]  address,
   input  ext_mem_storage_pkg::data_t  wdata,
   input  ext_mem_storage_pkg::symen_t byteenable,
   input  logic                        chipselect,
   input  logic                        read,
   input  logic                        write,
   input  logic                        outputenable,

   // split data bus, rdrive marks when the model owns it
   output ext_mem_storage_pkg::data_t  rdata,
   output logic                        rdrive
);

   // decoded command, decoder to array and read path
   ext_mem_cmd_if cmd_bus ();

   // masked read word and drive flag out of the array
   ext_mem_cmd_pkg::read_capture_t capture;

   // ----------------------------------------
   // submodules
   // ----------------------------------------

   conduit_decoder u_decoder (
      .clk            (clk),
      .internal_reset (internal_reset),
      .address        (address),
      .byteenable     (byteenable),
      .chipselect     (chipselect),
      .read           (read),
      .write          (write),
      .outputenable   (outputenable),
      .cmd            (cmd_bus.decoder)
   );

   mem_array u_array (
      .clk            (clk),
      .internal_reset (internal_reset),
      .cmd            (cmd_bus.consumer),
      .wdata          (wdata),
      .capture        (capture)
   );

   // latency and the bus-drive gating
   read_delay_line u_delay (
      .clk            (clk),
      .internal_reset (internal_reset),
      .capture        (capture),
      .rdata          (rdata),
      .rdrive         (rdrive)
   );

endmodule

// ==== design/read_delay_line.sv ====
`timescale 1ns/1ns

`include "ext_mem_settings.svh"

module read_delay_line (
   input  logic                           clk,
   input  logic                           internal_reset,
   input  ext_mem_cmd_pkg::read_capture_t capture,
   output ext_mem_storage_pkg::data_t     rdata,
   output logic                           rdrive
);

   localparam int latency = `EXT_MEM_READ_LATENCY;

   // last stage of the pipe or the live capture when latency is zero
   ext_mem_cmd_pkg::read_capture_t out_stage;

   // ----------------------------------------
   // latency pipeline
   // ----------------------------------------

   if (latency == 0) begin : g_passthru

      // combinational read that follows the current command
      assign out_stage = capture;

   end else begin : g_pipe

      // drive flags per stage with stage 0 the newest
      logic [latency-1:0]         drive_q;

      // read words per stage
      ext_mem_storage_pkg::data_t data_q [latency];

      // word and flag move one stage per clock
      always_ff @(posedge clk or posedge internal_reset) begin
         if (internal_reset) begin
            drive_q <= '0;
            for (int i = 0; i < latency; i++) begin
               data_q[i] <= '0;
            end
         end else begin
            drive_q[0] <= capture.drive;
            data_q[0]  <= capture.data;
            for (int i = 1; i < latency; i++) begin
               drive_q[i] <= drive_q[i-1];
               data_q[i]  <= data_q[i-1];
            end
         end
      end

      assign out_stage.data  = data_q[latency-1];
      assign out_stage.drive = drive_q[latency-1];

   end

   // ----------------------------------------
   // output stage
   // ----------------------------------------

   // zero stands in for the high impedance of the tristate bus
   assign rdrive = out_stage.drive;
   assign rdata  = out_stage.drive ? out_stage.data : '0;

   // the flag must be clean from the whole decoder to pin path
   a_rdrive_known: assert property (
      @(posedge clk) disable iff (internal_reset)
      !$isunknown(rdrive)
   );

endmodule

// ==== design/mem_array.sv ====
`timescale 1ns/1ns

module mem_array (
   input  logic                           clk,
   input  logic                           internal_reset,
   ext_mem_cmd_if.consumer                cmd,
   input  ext_mem_storage_pkg::data_t     wdata,
   output ext_mem_cmd_pkg::read_capture_t capture
);

   // word storage, one entry per word address
   ext_mem_storage_pkg::data_t mem [ext_mem_storage_pkg::num_words];

   // word currently addressed, used by both read and merge
   ext_mem_storage_pkg::data_t cur_word;

   // bit mask built from the symbol enables
   ext_mem_storage_pkg::data_t sym_mask;

   // old word with the enabled symbols replaced
   ext_mem_storage_pkg::data_t merged_word;

   assign cur_word = mem[cmd.cmd.addr];
   assign sym_mask = ext_mem_storage_pkg::symbol_mask(cmd.cmd.symen);

   // ----------------------------------------
   // write merge
   // ----------------------------------------

   // keep disabled symbols, take enabled ones from wdata
   assign merged_word = (cur_word & ~sym_mask) | (wdata & sym_mask);

   // a read at the same edge still sees the old word
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int w = 0; w < ext_mem_storage_pkg::num_words; w++) begin
            mem[w] <= '0;
         end
      end else if (cmd.cmd.write) begin
         mem[cmd.cmd.addr] <= merged_word;
      end
   end

   // ----------------------------------------
   // read capture
   // ----------------------------------------

   always_comb begin
      // disabled symbols read back as zero
      capture.data  = cur_word & sym_mask;

      // read is already gated with cs and cleared on write
      capture.drive = cmd.cmd.read & cmd.cmd.oe;
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // the bus master must hold the write strobe idle while reset is up,
   // otherwise the cleared contents would be overwritten right after release
   a_no_write_in_reset: assert property (
      @(posedge clk)
      !(internal_reset && cmd.cmd.write)
   );

endmodule

// ==== design/conduit_decoder.sv ====
`timescale 1ns/1ns

`include "ext_mem_settings.svh"

module conduit_decoder (
   // clk and reset only serve the assertion sampling
   input  logic                                clk,
   input  logic                                internal_reset,
   input  logic [`EXT_MEM_ADDR_W-1:0]          address,
   input  ext_mem_storage_pkg::symen_t         byteenable,
   input  logic                                chipselect,
   input  logic                                read,
   input  logic                                write,
   input  logic                                outputenable,
   ext_mem_cmd_if.decoder                      cmd
);

   // number of byte address bits below the word index
   localparam int sym_lsb = $clog2(`EXT_MEM_NUM_SYMBOLS);

   // pins after polarity correction, all active high
   logic                        cs_act;
   logic                        rd_act;
   logic                        wr_act;
   logic                        oe_act;
   ext_mem_storage_pkg::symen_t symen_act;

   // assembled command before it goes onto the interface
   ext_mem_cmd_pkg::mem_cmd_t   dec;

   // ----------------------------------------
   // polarity correction
   // ----------------------------------------

   // xor with the active-low flag flips only the low-true pins
   assign cs_act = chipselect   ^ (`EXT_MEM_ACTIVE_LOW_CS != 0);
   assign rd_act = read         ^ (`EXT_MEM_ACTIVE_LOW_READ != 0);
   assign wr_act = write        ^ (`EXT_MEM_ACTIVE_LOW_WRITE != 0);
   assign oe_act = outputenable ^ (`EXT_MEM_ACTIVE_LOW_OE != 0);

   // every byte lane shares one polarity flag
   assign symen_act = byteenable ^
      {`EXT_MEM_NUM_SYMBOLS{(`EXT_MEM_ACTIVE_LOW_BYTEEN != 0)}};

   // ----------------------------------------
   // command forming
   // ----------------------------------------

   always_comb begin
      // nothing happens without chip select
      dec.write = cs_act & wr_act;

      // write wins when both strobes are up
      dec.read  = cs_act & rd_act & ~wr_act;

      // oe passes through, drive is decided downstream
      dec.oe    = oe_act;
      dec.symen = symen_act;

      // byte address to word index, low symbol bits dropped
      dec.addr  = ext_mem_storage_pkg::word_addr_t'(address >> sym_lsb);
   end

   assign cmd.cmd = dec;

   // ----------------------------------------
   // checks
   // ----------------------------------------

   // the array and the read path see at most one strobe per cycle
   a_rd_wr_exclusive: assert property (
      @(posedge clk) disable iff (internal_reset)
      !(cmd.cmd.read && cmd.cmd.write)
   );

endmodule

// ==== design/ext_mem_cmd_if.sv ====
`timescale 1ns/1ns

// decoded conduit command shared by the decoder, array and read path
interface ext_mem_cmd_if;

   // level signal, valid for the whole cycle
   // consumers sample it at the rising clk edge
   ext_mem_cmd_pkg::mem_cmd_t cmd;

   // ----------------------------------------
   // modports
   // ----------------------------------------

   // the decoder is the only driver
   modport decoder (
      output cmd
   );

   // storage array and read path only look at it
   modport consumer (
      input cmd
   );

endinterface

// ==== design/ext_mem_cmd_pkg.sv ====
package ext_mem_cmd_pkg;

   // ----------------------------------------
   // decoded bus command
   // ----------------------------------------

   // all strobes here are active high and already gated by chip select
   // read is dropped whenever write is also present
   typedef struct packed {
      ext_mem_storage_pkg::word_addr_t addr;
      logic                            read;
      logic                            write;
      logic                            oe;
      ext_mem_storage_pkg::symen_t     symen;
   } mem_cmd_t;

   // ----------------------------------------
   // read word on its way to the pins
   // ----------------------------------------

   // data is already masked by the symbol enables
   // drive marks a cycle where the model would own the data bus
   typedef struct packed {
      ext_mem_storage_pkg::data_t data;
      logic                       drive;
   } read_capture_t;

endpackage

// ==== design/ext_mem_storage_pkg.sv ====
`include "ext_mem_settings.svh"

package ext_mem_storage_pkg;

   // word geometry derived from the settings header
   localparam int num_symbols = `EXT_MEM_NUM_SYMBOLS;
   localparam int symbol_w    = `EXT_MEM_SYMBOL_W;
   localparam int data_w      = num_symbols * symbol_w;

   // low address bits select a symbol, the rest select a word
   localparam int word_addr_w = `EXT_MEM_ADDR_W - $clog2(num_symbols);
   localparam int num_words   = 2 ** word_addr_w;

   typedef logic [data_w-1:0]      data_t;
   typedef logic [num_symbols-1:0] symen_t;
   typedef logic [word_addr_w-1:0] word_addr_t;

   // spread each enable bit over all bits of its symbol
   function automatic data_t symbol_mask(input symen_t symen);
      data_t mask;
      for (int s = 0; s < num_symbols; s++) begin
         mask[s*symbol_w +: symbol_w] = {symbol_w{symen[s]}};
      end
      return mask;
   endfunction

endpackage

// ==== design/ext_mem_settings.svh ====
`ifndef EXT_MEM_SETTINGS_SVH
`define EXT_MEM_SETTINGS_SVH

// ----------------------------------------
// geometry of the conduit memory
// ----------------------------------------

// width of the byte address on the conduit
`define EXT_MEM_ADDR_W 8

// symbols per memory word
`define EXT_MEM_NUM_SYMBOLS 4

// bits in one symbol
`define EXT_MEM_SYMBOL_W 8

// clocks from read sample to data on rdata
// zero makes the read path purely combinational
`define EXT_MEM_READ_LATENCY 2

// ----------------------------------------
// pin polarity, 1 means active low
// ----------------------------------------

// chip select
`define EXT_MEM_ACTIVE_LOW_CS 0

// read strobe
`define EXT_MEM_ACTIVE_LOW_READ 0

// write strobe, active low by default
`define EXT_MEM_ACTIVE_LOW_WRITE 1

// output enable
`define EXT_MEM_ACTIVE_LOW_OE 0

// byte enables, all lanes share one polarity
`define EXT_MEM_ACTIVE_LOW_BYTEEN 0

`endif
